/* source/gf_pkg.sv */
`default_nettype none

package gf_pkg;

	// GF(2^8) arithmetic over the fixed field x^8 + x^4 + x^3 + x^2 + 1

	localparam int GF_M = 8;	// Field degree, also the element width
	localparam int RAM_DEPTH = 64;	// Words in the operand memory

	// One field element in standard basis, bit i is the coefficient of x^i
	typedef logic [GF_M-1:0] elem_t;

	// Word address into the operand memory
	typedef logic [$clog2(RAM_DEPTH)-1:0] addr_t;

	// Reduction pattern, the x^8 term is implied
	localparam elem_t GF_POLY = 8'h1D;

	// Bus arbiter states
	typedef enum logic {
		ARB_IDLE,	// No master owns the memory
		ARB_GRANTED	// Grant held until the owner drops cyc
	} arb_state_t;

endpackage

`default_nettype wire

/* source/wb_if.sv */
`default_nettype none
`timescale 1ns/100ps

interface wb_if;
	import gf_pkg::*;

	logic cyc;
	logic stb;
	logic we;	// High for a write transfer
	addr_t adr;
	elem_t dat_w;	// Master to slave data
	elem_t dat_r;	// Slave to master data, valid with ack
	logic ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	modport slave (
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

`default_nettype wire

/* source/gf_ram.sv */
`default_nettype none
`timescale 1ns/100ps

module gf_ram (
	input logic clk,
	input logic reset,
	wb_if.slave bus
);
	import gf_pkg::*;

	elem_t mem [RAM_DEPTH];	// Operand storage
	elem_t rd_data;
	logic ack;
	logic access;

	// A new transfer starts only while ack is low, so each ack is one cycle
	assign access = bus.cyc && bus.stb && !ack;

	always_ff @(posedge clk) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we) begin
				mem[bus.adr] <= bus.dat_w;	// Lands on the edge that raises ack
			end
			rd_data <= mem[bus.adr];	// Shows up in the ack cycle
		end
	end

	assign bus.ack = ack;
	assign bus.dat_r = rd_data;

endmodule

`default_nettype wire

/* source/wb_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module wb_arbiter (
	input logic clk,
	input logic reset,
	wb_if.slave host,
	wb_if.slave mul,
	wb_if.slave inv,
	wb_if.master mem
);
	import gf_pkg::*;

	arb_state_t state;
	logic [1:0] gnt;	// Owner index, 0 host, 1 mul, 2 inv
	logic [1:0] ptr;	// First master looked at on the next grant
	logic [1:0] pick;
	logic found;
	logic [2:0] req;
	logic sel_host;
	logic sel_mul;
	logic sel_inv;

	// Index base + off, wrapped over the three masters
	function automatic logic [1:0] rr_next(input logic [1:0] base, input logic [1:0] off);
		logic [2:0] sum;
		sum = {1'b0, base} + {1'b0, off};
		return (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
	endfunction

	assign req = {inv.cyc, mul.cyc, host.cyc};

	// First requester at or after ptr
	always_comb begin
		pick = ptr;
		found = 1'b0;
		for (int i = 0; i < 3; i++) begin
			if (!found && req[rr_next(ptr, 2'(i))]) begin
				pick = rr_next(ptr, 2'(i));
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ARB_IDLE;
			gnt <= 2'd0;
			ptr <= 2'd0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (found) begin
						state <= ARB_GRANTED;
						gnt <= pick;
					end
				end
				ARB_GRANTED: begin
					if (!req[gnt]) begin
						state <= ARB_IDLE;
						ptr <= rr_next(gnt, 2'd1);	// Served master goes last
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	assign sel_host = (state == ARB_GRANTED) && (gnt == 2'd0);
	assign sel_mul = (state == ARB_GRANTED) && (gnt == 2'd1);
	assign sel_inv = (state == ARB_GRANTED) && (gnt == 2'd2);

	always_comb begin
		mem.cyc = 1'b0;	// Bus stays quiet while idle
		mem.stb = 1'b0;
		mem.we = host.we;
		mem.adr = host.adr;
		mem.dat_w = host.dat_w;
		if (sel_host) begin
			mem.cyc = host.cyc;
			mem.stb = host.stb;
		end else if (sel_mul) begin
			mem.cyc = mul.cyc;
			mem.stb = mul.stb;
			mem.we = mul.we;
			mem.adr = mul.adr;
			mem.dat_w = mul.dat_w;
		end else if (sel_inv) begin
			mem.cyc = inv.cyc;
			mem.stb = inv.stb;
			mem.we = inv.we;
			mem.adr = inv.adr;
			mem.dat_w = inv.dat_w;
		end
	end

	assign host.ack = sel_host && mem.ack;
	assign mul.ack = sel_mul && mem.ack;
	assign inv.ack = sel_inv && mem.ack;
	assign host.dat_r = sel_host ? mem.dat_r : '0;
	assign mul.dat_r = sel_mul ? mem.dat_r : '0;
	assign inv.dat_r = sel_inv ? mem.dat_r : '0;

endmodule

`default_nettype wire

/* source/gf_mul_engine.sv */
`default_nettype none
`timescale 1ns/100ps

module gf_mul_engine (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_pkg::addr_t adr_a,
	input gf_pkg::addr_t adr_b,
	input gf_pkg::addr_t adr_p,
	output logic busy,
	output logic done,
	wb_if.master bus
);
	import gf_pkg::*;

	typedef enum logic [2:0] {
		MUL_IDLE,
		MUL_RD_A,
		MUL_RD_B,
		MUL_CALC,
		MUL_WR
	} mul_state_t;

	mul_state_t state;
	addr_t a_adr;	// Addresses latched at start
	addr_t b_adr;
	addr_t p_adr;
	elem_t op_a;
	elem_t op_b;	// Shifted left, MSB drives each step
	elem_t acc;
	elem_t acc_next;
	logic [$clog2(GF_M)-1:0] cnt;
	logic cyc;
	logic we;
	addr_t adr;
	elem_t dat_w;

	// Horner step of the serial standard basis multiplier
	assign acc_next = {acc[GF_M-2:0], 1'b0}
		^ (acc[GF_M-1] ? GF_POLY : '0)
		^ (op_b[GF_M-1] ? op_a : '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= MUL_IDLE;
			cyc <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				MUL_IDLE: begin
					if (start) begin
						a_adr <= adr_a;
						b_adr <= adr_b;
						p_adr <= adr_p;
						state <= MUL_RD_A;
					end
				end
				MUL_RD_A: begin
					if (!cyc) begin
						cyc <= 1'b1;
						we <= 1'b0;
						adr <= a_adr;
					end else if (bus.ack) begin
						cyc <= 1'b0;	// Released for at least one cycle
						op_a <= bus.dat_r;
						state <= MUL_RD_B;
					end
				end
				MUL_RD_B: begin
					if (!cyc) begin
						cyc <= 1'b1;
						we <= 1'b0;
						adr <= b_adr;
					end else if (bus.ack) begin
						cyc <= 1'b0;
						op_b <= bus.dat_r;
						acc <= '0;
						cnt <= '0;
						state <= MUL_CALC;
					end
				end
				MUL_CALC: begin
					acc <= acc_next;
					op_b <= op_b << 1;
					cnt <= cnt + 1'b1;
					if (cnt == ($clog2(GF_M))'(GF_M - 1)) begin
						state <= MUL_WR;
					end
				end
				MUL_WR: begin
					if (!cyc) begin
						cyc <= 1'b1;
						we <= 1'b1;
						adr <= p_adr;
						dat_w <= acc;
					end else if (bus.ack) begin
						cyc <= 1'b0;
						done <= 1'b1;	// Same cycle that busy falls
						state <= MUL_IDLE;
					end
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

	assign busy = (state != MUL_IDLE);
	assign bus.cyc = cyc;
	assign bus.stb = cyc;
	assign bus.we = we;
	assign bus.adr = adr;
	assign bus.dat_w = dat_w;

endmodule

`default_nettype wire

/* source/gf_inv_engine.sv */
`default_nettype none
`timescale 1ns/100ps

module gf_inv_engine (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_pkg::addr_t adr_a,
	input gf_pkg::addr_t adr_r,
	output logic busy,
	output logic done,
	wb_if.master bus
);
	import gf_pkg::*;

	typedef enum logic [1:0] {
		INV_IDLE,
		INV_RD_A,
		INV_CALC,
		INV_WR
	} inv_state_t;

	inv_state_t state;
	addr_t a_adr;
	addr_t r_adr;
	elem_t pow_q;	// Holds a^(2^k)
	elem_t res_q;	// Running product of the squares
	elem_t pow_sq;
	elem_t res_next;
	logic [$clog2(GF_M)-1:0] cnt;
	logic cyc;
	logic we;
	addr_t adr;
	elem_t dat_w;

	// Fold a degree 2m-2 polynomial back into the field
	function automatic elem_t gf_reduce(input logic [2*GF_M-2:0] wide);
		logic [2*GF_M-2:0] v;
		v = wide;
		for (int i = 2*GF_M-2; i >= GF_M; i--) begin
			if (v[i]) begin
				v = v ^ ((2*GF_M-1)'({1'b1, GF_POLY}) << (i - GF_M));
			end
		end
		return v[GF_M-1:0];
	endfunction

	function automatic elem_t gf_mul(input elem_t x, input elem_t y);
		logic [2*GF_M-2:0] prod;
		prod = '0;
		for (int i = 0; i < GF_M; i++) begin
			if (y[i]) begin
				prod = prod ^ ((2*GF_M-1)'(x) << i);
			end
		end
		return gf_reduce(prod);
	endfunction

	// Squaring is linear, coefficient i moves to position 2i
	function automatic elem_t gf_sq(input elem_t x);
		logic [2*GF_M-2:0] spread;
		spread = '0;
		for (int i = 0; i < GF_M; i++) begin
			spread[2*i] = x[i];
		end
		return gf_reduce(spread);
	endfunction

	assign pow_sq = gf_sq(pow_q);
	assign res_next = gf_mul(res_q, pow_sq);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= INV_IDLE;
			cyc <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				INV_IDLE: begin
					if (start) begin
						a_adr <= adr_a;
						r_adr <= adr_r;
						state <= INV_RD_A;
					end
				end
				INV_RD_A: begin
					if (!cyc) begin
						cyc <= 1'b1;
						we <= 1'b0;
						adr <= a_adr;
					end else if (bus.ack) begin
						cyc <= 1'b0;
						pow_q <= bus.dat_r;
						res_q <= elem_t'(1);
						cnt <= '0;
						state <= INV_CALC;
					end
				end
				INV_CALC: begin
					pow_q <= pow_sq;
					res_q <= res_next;	// a^2 * a^4 * ... * a^128 = a^254
					cnt <= cnt + 1'b1;
					if (cnt == ($clog2(GF_M))'(GF_M - 2)) begin
						state <= INV_WR;
					end
				end
				INV_WR: begin
					if (!cyc) begin
						cyc <= 1'b1;
						we <= 1'b1;
						adr <= r_adr;
						dat_w <= res_q;
					end else if (bus.ack) begin
						cyc <= 1'b0;
						done <= 1'b1;
						state <= INV_IDLE;
					end
				end
				default: state <= INV_IDLE;
			endcase
		end
	end

	assign busy = (state != INV_IDLE);
	assign bus.cyc = cyc;
	assign bus.stb = cyc;
	assign bus.we = we;
	assign bus.adr = adr;
	assign bus.dat_w = dat_w;

endmodule

`default_nettype wire

/* source/gf_coproc.sv */
`default_nettype none
`timescale 1ns/100ps

module gf_coproc (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input gf_pkg::addr_t wb_adr,
	input gf_pkg::elem_t wb_dat_w,
	output gf_pkg::elem_t wb_dat_r,
	output logic wb_ack,
	input logic mul_start,
	input gf_pkg::addr_t mul_adr_a,
	input gf_pkg::addr_t mul_adr_b,
	input gf_pkg::addr_t mul_adr_p,
	output logic mul_busy,
	output logic mul_done,
	input logic inv_start,
	input gf_pkg::addr_t inv_adr_a,
	input gf_pkg::addr_t inv_adr_r,
	output logic inv_busy,
	output logic inv_done
);

	wb_if host_bus ();	// Host port into the arbiter
	wb_if mul_bus ();
	wb_if inv_bus ();
	wb_if mem_bus ();	// Arbiter to memory

	assign host_bus.cyc = wb_cyc;
	assign host_bus.stb = wb_stb;
	assign host_bus.we = wb_we;
	assign host_bus.adr = wb_adr;
	assign host_bus.dat_w = wb_dat_w;
	assign wb_dat_r = host_bus.dat_r;
	assign wb_ack = host_bus.ack;

	gf_ram ram0 (
		.clk(clk),
		.reset(reset),
		.bus(mem_bus.slave)
	);

	wb_arbiter arb0 (
		.clk(clk),
		.reset(reset),
		.host(host_bus.slave),
		.mul(mul_bus.slave),
		.inv(inv_bus.slave),
		.mem(mem_bus.master)
	);

	gf_mul_engine mul0 (
		.clk(clk),
		.reset(reset),
		.start(mul_start),
		.adr_a(mul_adr_a),
		.adr_b(mul_adr_b),
		.adr_p(mul_adr_p),
		.busy(mul_busy),
		.done(mul_done),
		.bus(mul_bus.master)
	);

	gf_inv_engine inv0 (
		.clk(clk),
		.reset(reset),
		.start(inv_start),
		.adr_a(inv_adr_a),
		.adr_r(inv_adr_r),
		.busy(inv_busy),
		.done(inv_done),
		.bus(inv_bus.master)
	);

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clock (
	output logic clk
);

	localparam realtime HALF_PERIOD = 4ns;	// 8 ns period

	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

/* sim/gf_coproc_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module gf_coproc_tb;
	import gf_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam logic [31:0] SEED = 32'hd7cd;
	localparam logic [7:0] FIELD_POLY = 8'h1D;	// x^8 + x^4 + x^3 + x^2 + 1, top term implied
	localparam int N_MUL_RAND = 12;
	localparam int N_MUL = N_MUL_RAND + 6;	// Six fixed pairs with 0, 1 and 8'hFF
	localparam int N_INV_RAND = 12;
	localparam int N_INV = N_INV_RAND + 2;
	localparam int N_CONC_READS = 32;
	localparam int ACCESSES = 2 * RAM_DEPTH + N_MUL * 6 + N_INV * 4 + N_CONC_READS + 10;
	localparam int WORST_WAIT = 3 * 6;	// Own access plus two others, about six cycles each
	localparam int COMPUTE = N_MUL * GF_M + N_INV * (GF_M - 1) + 2 * GF_M;
	localparam int TIMEOUT_CYCLES = 2 * (ACCESSES * WORST_WAIT + COMPUTE + RESET_CYCLES);

	localparam addr_t MUL_A = 6'd0;
	localparam addr_t MUL_B = 6'd1;
	localparam addr_t MUL_P = 6'd2;
	localparam addr_t INV_A = 6'd3;
	localparam addr_t INV_R = 6'd4;
	localparam addr_t CONC_A = 6'd8;
	localparam addr_t CONC_B = 6'd9;
	localparam addr_t CONC_P = 6'd10;
	localparam addr_t CONC_I = 6'd11;
	localparam addr_t CONC_R = 6'd12;
	localparam int CONC_FIRST = 16;	// Host reads these words during the engine runs

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	elem_t wb_dat_w;
	elem_t wb_dat_r;
	logic wb_ack;
	logic mul_start;
	addr_t mul_adr_a;
	addr_t mul_adr_b;
	addr_t mul_adr_p;
	logic mul_busy;
	logic mul_done;
	logic inv_start;
	addr_t inv_adr_a;
	addr_t inv_adr_r;
	logic inv_busy;
	logic inv_done;

	logic [31:0] rng_state = SEED;
	elem_t shadow [RAM_DEPTH];	// Last value the host wrote to each word
	int cycles = 0;

	tb_clock clock0 (
		.clk(clk)
	);

	gf_coproc dut0 (.*);

	task automatic stop_run();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("Failure: %s", what);
		stop_run();
	endtask

	task automatic report_mismatch(input string test, input elem_t exp, input elem_t act);
		$display("** Error %s: expected %h, actual %h", test, exp, act);
		stop_run();
	endtask

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Shift-and-add over the field, one bit of b per step
	function automatic elem_t field_mul(input elem_t a, input elem_t b);
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] p;
		x = a;
		y = b;
		p = 8'h00;
		for (int i = 0; i < 8; i++) begin
			if (y[0]) begin
				p = p ^ x;
			end
			y = y >> 1;
			x = x[7] ? ((x << 1) ^ FIELD_POLY) : (x << 1);
		end
		return p;
	endfunction

	// The element whose product with a is one, zero when none exists
	function automatic elem_t field_inverse(input elem_t a);
		elem_t inv;
		inv = 8'h00;
		for (int c = 1; c < 256; c++) begin
			if (field_mul(a, elem_t'(c)) == 8'h01) begin
				inv = elem_t'(c);
			end
		end
		return inv;
	endfunction

	task automatic write_word(input addr_t adr, input elem_t data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= data;
		do begin
			@(negedge clk);
		end while (!wb_ack);
		@(posedge clk);
		wb_cyc <= 1'b0;	// Released in the cycle after ack
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic read_word(input addr_t adr, output elem_t data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		do begin
			@(negedge clk);
		end while (!wb_ack);
		data = wb_dat_r;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic wait_mul_done();
		do begin
			@(negedge clk);
		end while (!mul_done);
	endtask

	task automatic wait_inv_done();
		do begin
			@(negedge clk);
		end while (!inv_done);
	endtask

	task automatic run_multiply(input elem_t a, input elem_t b);
		elem_t got;
		elem_t exp;
		exp = field_mul(a, b);
		write_word(MUL_A, a);
		write_word(MUL_B, b);
		@(posedge clk);
		mul_start <= 1'b1;
		mul_adr_a <= MUL_A;
		mul_adr_b <= MUL_B;
		mul_adr_p <= MUL_P;
		@(posedge clk);
		mul_start <= 1'b0;
		wait_mul_done();
		read_word(MUL_P, got);
		assert (got == exp) else report_mismatch("multiply", exp, got);
	endtask

	task automatic run_inverse(input elem_t a);
		elem_t got;
		elem_t exp;
		exp = field_inverse(a);
		write_word(INV_A, a);
		@(posedge clk);
		inv_start <= 1'b1;
		inv_adr_a <= INV_A;
		inv_adr_r <= INV_R;
		@(posedge clk);
		inv_start <= 1'b0;
		wait_inv_done();
		read_word(INV_R, got);
		assert (got == exp) else report_mismatch("inverse", exp, got);
		if (a != 8'h00) begin
			assert (field_mul(a, got) == 8'h01)
				else report_mismatch("inverse product", 8'h01, field_mul(a, got));
		end
	endtask

	// Bus and engine protocol rules, sampled on every edge
	assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
		else report_failure("host ack stayed high for more than one cycle");
	assert property (@(posedge clk) disable iff (reset) mul_done |-> $past(mul_busy) && !mul_busy)
		else report_failure("mul_done came without a preceding busy period");
	assert property (@(posedge clk) disable iff (reset) mul_done |=> !mul_done)
		else report_failure("mul_done lasted more than one cycle");
	assert property (@(posedge clk) disable iff (reset) inv_done |-> $past(inv_busy) && !inv_busy)
		else report_failure("inv_done came without a preceding busy period");
	assert property (@(posedge clk) disable iff (reset) inv_done |=> !inv_done)
		else report_failure("inv_done lasted more than one cycle");

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			report_failure("timeout, an access or engine run never completed");
		end
	end

	initial begin
		elem_t got;
		elem_t a;
		elem_t ca;
		elem_t cb;
		elem_t ci;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		mul_start = 1'b0;
		mul_adr_a = '0;
		mul_adr_b = '0;
		mul_adr_p = '0;
		inv_start = 1'b0;
		inv_adr_a = '0;
		inv_adr_r = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		repeat (3) begin
			@(negedge clk);
			assert (!wb_ack && !mul_busy && !mul_done && !inv_busy && !inv_done)
				else report_failure("status outputs were not low after reset");
		end

		for (int i = 0; i < RAM_DEPTH; i++) begin
			shadow[i] = elem_t'(next_random());
			write_word(addr_t'(i), shadow[i]);
		end
		for (int i = 0; i < RAM_DEPTH; i++) begin
			read_word(addr_t'(i), got);
			assert (got == shadow[i]) else report_mismatch("readback", shadow[i], got);
		end

		run_multiply(8'h00, elem_t'(next_random()));
		run_multiply(elem_t'(next_random()), 8'h00);
		run_multiply(8'h01, elem_t'(next_random()));
		run_multiply(elem_t'(next_random()), 8'h01);
		run_multiply(8'hFF, 8'hFF);
		run_multiply(8'hFF, elem_t'(next_random()));
		for (int i = 0; i < N_MUL_RAND; i++) begin
			run_multiply(elem_t'(next_random()), elem_t'(next_random()));
		end

		run_inverse(8'h00);
		run_inverse(8'h01);
		for (int i = 0; i < N_INV_RAND; i++) begin
			do begin
				a = elem_t'(next_random());
			end while (a == 8'h00);
			run_inverse(a);
		end

		// Both engines start together while the host keeps the bus busy
		ca = elem_t'(next_random());
		cb = elem_t'(next_random());
		ci = elem_t'(next_random());
		write_word(CONC_A, ca);
		write_word(CONC_B, cb);
		write_word(CONC_I, ci);
		@(posedge clk);
		mul_start <= 1'b1;
		mul_adr_a <= CONC_A;
		mul_adr_b <= CONC_B;
		mul_adr_p <= CONC_P;
		inv_start <= 1'b1;
		inv_adr_a <= CONC_I;
		inv_adr_r <= CONC_R;
		@(posedge clk);
		mul_start <= 1'b0;
		inv_start <= 1'b0;
		fork
			for (int k = 0; k < N_CONC_READS; k++) begin
				read_word(addr_t'(CONC_FIRST + k), got);
				assert (got == shadow[CONC_FIRST + k])
					else report_mismatch("concurrent read", shadow[CONC_FIRST + k], got);
			end
			wait_mul_done();
			wait_inv_done();
		join
		read_word(CONC_P, got);
		assert (got == field_mul(ca, cb))
			else report_mismatch("concurrent multiply", field_mul(ca, cb), got);
		read_word(CONC_R, got);
		assert (got == field_inverse(ci))
			else report_mismatch("concurrent inverse", field_inverse(ci), got);

		repeat (2) @(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* gf_coproc.f */
source/gf_pkg.sv
source/wb_if.sv
source/gf_ram.sv
source/wb_arbiter.sv
source/gf_mul_engine.sv
source/gf_inv_engine.sv
source/gf_coproc.sv
sim/tb_clock.sv
sim/gf_coproc_tb.sv

/* Makefile */
# Verilator build and run for the GF(2^8) coprocessor testbench

VERILATOR ?= verilator
TOP ?= gf_coproc_tb
FILELIST ?= gf_coproc.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
